//--- sim.f
rtl/dab_pkg.sv
rtl/dab_apb_regs.sv
rtl/dab_compare_calc.sv
rtl/dab_modulator_ctrl.sv
rtl/dab_pwm_core.sv
rtl/dab_top.sv
dv/dab_props.sv
dv/dab_tb.sv

//--- Bender.yml
package:
  name: dab_modulator

sources:
  - files:
      - rtl/dab_pkg.sv
      - rtl/dab_apb_regs.sv
      - rtl/dab_compare_calc.sv
      - rtl/dab_modulator_ctrl.sv
      - rtl/dab_pwm_core.sv
      - rtl/dab_top.sv
  - target: test
    files:
      - dv/dab_props.sv
      - dv/dab_tb.sv

//--- dv/dab_tb.sv
// Directed testbench for dab_top; PWM edges are timed from the rise of channel 0
`timescale 1ns/1ps
`default_nettype none

module dab_tb;
    import dab_pkg::*;

    localparam int TIMEOUT_CYCLES = 6000;

    logic clock;
    logic reset;
    logic psel;
    logic penable;
    logic pwrite;
    logic [APB_AW-1:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic pready;
    logic pslverr;
    logic [N_CH-1:0] pwm_out;
    dab_status_t status;
    int cycle_count = 0;
    integer seed;

    dab_top UUT (
        .clock(clock), .reset(reset), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .pwm_out(pwm_out), .status(status)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            fail_run("Timeout: the tests did not finish within the cycle limit");
        end else if (assertion_failures() != 0) begin
            fail_run("A bound assertion in dab_props failed");
        end
    end

    function automatic int assertion_failures();
        return UUT.ctrl.ctrl_props.fail_count + UUT.pwm.pwm_props.fail_count;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("ERR %0t %s got 0x%0h expected 0x%0h", $time, name, got, exp));
        end
    endtask

    task automatic check_status(input string name, input dab_status_t got, input dab_status_t exp);
        if (got !== exp) begin
            fail_run($sformatf("ERR %0t %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    task automatic check_bool(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("ERR %0t %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    // Measured edges are relative to the rise of channel 0, so the model is shifted the same way
    task automatic check_edges(input edge_set_t got, input edge_set_t model);
        logic [DATA_W-1:0] exp_val;
        for (int k = 0; k < N_CH; k++) begin
            exp_val = model.rise[k] - model.rise[0];
            if (got.rise[k] !== exp_val) begin
                fail_run($sformatf("ERR %0t rise[%0d] got %0d expected %0d",
                    $time, k, got.rise[k], exp_val));
            end
            exp_val = model.fall[k] - model.rise[0];
            if (got.fall[k] !== exp_val) begin
                fail_run($sformatf("ERR %0t fall[%0d] got %0d expected %0d",
                    $time, k, got.fall[k], exp_val));
            end
        end
    endtask

    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [31:0] data,
        output logic err);
        psel = 1'b1;
        pwrite = 1'b1;
        paddr = addr;
        pwdata = data;
        next_cycle();
        penable = 1'b1;
        @(negedge clock);
        check_bool("pready", pready, 1'b1);
        err = pslverr;
        next_cycle();
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [31:0] data,
        output logic err);
        psel = 1'b1;
        pwrite = 1'b0;
        paddr = addr;
        next_cycle();
        penable = 1'b1;
        @(negedge clock);
        check_bool("pready", pready, 1'b1);
        data = prdata;
        err = pslverr;
        next_cycle();
        psel = 1'b0;
        penable = 1'b0;
    endtask

    // Edge model from half period, half duty and halved phases, shifted per channel
    function automatic edge_set_t expected_edges(input mod_mode_e mode, input int period,
        input int duty, input int phase_1, input int phase_2);
        edge_set_t e;
        int shift [N_CH];
        int p1;
        int p2;
        p1 = phase_1 / 2;
        p2 = phase_2 / 2;
        shift[0] = 0;
        shift[1] = (mode == MODE_DPS) ? p2 : 0;
        shift[2] = p1;
        shift[3] = (mode == MODE_DPS) ? p1 + p2 : p1;
        for (int k = 0; k < N_CH; k++) begin
            e.rise[k] = DATA_W'(period / 2 - duty / 2 + shift[k]);
            e.fall[k] = DATA_W'(period / 2 + duty / 2 + shift[k]);
        end
        return e;
    endfunction

    task automatic measure_edges(input int limit, output edge_set_t meas, output int period);
        logic [N_CH-1:0] prev;
        logic done;
        int rise_at [N_CH];
        int fall_at [N_CH];
        int next_rise;
        int n;
        for (int k = 0; k < N_CH; k++) begin
            rise_at[k] = -1;
            fall_at[k] = -1;
        end
        next_rise = -1;
        n = 0;
        done = 1'b0;
        @(negedge clock);
        prev = pwm_out;
        while (n < limit && !done) begin
            @(negedge clock);
            n++;
            for (int k = 0; k < N_CH; k++) begin
                if (pwm_out[k] && !prev[k]) begin
                    if (k == 0 && fall_at[0] >= 0 && next_rise < 0) begin
                        next_rise = n;
                    end else if (rise_at[k] < 0 && (k == 0 || rise_at[0] >= 0)) begin
                        rise_at[k] = n;
                    end
                end
                if (!pwm_out[k] && prev[k] && rise_at[k] >= 0 && fall_at[k] < 0) begin
                    fall_at[k] = n;
                end
            end
            prev = pwm_out;
            done = next_rise >= 0;
            for (int k = 0; k < N_CH; k++) begin
                if (fall_at[k] < 0) begin
                    done = 1'b0;
                end
            end
        end
        if (!done) begin
            fail_run("Not all PWM edges were seen within the measurement window");
        end
        for (int k = 0; k < N_CH; k++) begin
            meas.rise[k] = DATA_W'(rise_at[k] - rise_at[0]);
            meas.fall[k] = DATA_W'(fall_at[k] - rise_at[0]);
        end
        period = next_rise - rise_at[0];
        next_cycle();
    endtask

    task automatic check_pwm(input edge_set_t model, input int period);
        edge_set_t meas;
        int meas_period;
        measure_edges(3 * period, meas, meas_period);
        check_edges(meas, model);
        check_word("pwm period", meas_period, period);
    endtask

    task automatic write_params(input mod_mode_e mode, input int period, input int duty,
        input int phase_1, input int phase_2);
        logic err;
        apb_write(ADDR_MODE, 32'(mode), err);
        check_bool("pslverr", err, 1'b0);
        apb_write(ADDR_PERIOD, period, err);
        check_bool("pslverr", err, 1'b0);
        apb_write(ADDR_DUTY, duty, err);
        check_bool("pslverr", err, 1'b0);
        apb_write(ADDR_PHASE1, phase_1, err);
        check_bool("pslverr", err, 1'b0);
        apb_write(ADDR_PHASE2, phase_2, err);
        check_bool("pslverr", err, 1'b0);
    endtask

    // The command bits are start, stop and update from bit 0 upward
    task automatic send_cmd(input logic [2:0] bits);
        logic err;
        apb_write(ADDR_CTRL, 32'(bits), err);
        check_bool("pslverr", err, 1'b0);
    endtask

    task automatic wait_command_done();
        int n;
        n = 0;
        @(negedge clock);
        while (!status.busy && n < 4) begin
            @(negedge clock);
            n++;
        end
        if (!status.busy) begin
            fail_run("busy never rose after a command");
        end
        n = 0;
        while (status.busy && n < 16) begin
            @(negedge clock);
            n++;
        end
        if (status.busy) begin
            fail_run("busy stayed high after a command");
        end
        next_cycle();
    endtask

    // New values load at the next wrap, so one full period is skipped before measuring
    task automatic update_running(input int period);
        send_cmd(3'b100);
        wait_command_done();
        repeat (period) @(posedge clock);
        #1;
    endtask

    task automatic test_registers();
        logic [APB_AW-1:0] addrs [7] = '{ADDR_CTRL, ADDR_MODE, ADDR_PERIOD, ADDR_DUTY,
            ADDR_PHASE1, ADDR_PHASE2, ADDR_STATUS};
        logic [31:0] data;
        logic [31:0] value;
        logic err;
        check_word("pwm_out", 32'(pwm_out), 32'h0);
        check_status("status", status, '0);
        for (int i = 0; i < 7; i++) begin
            apb_read(addrs[i], data, err);
            check_word($sformatf("prdata at 0x%0h", addrs[i]), data, 32'h0);
            check_bool("pslverr", err, 1'b0);
        end
        for (int i = 1; i < 6; i++) begin
            value = $random(seed);
            value = (addrs[i] == ADDR_MODE) ? (value & 32'h1) : (value & 32'hFFFF);
            apb_write(addrs[i], value, err);
            check_bool("pslverr", err, 1'b0);
            apb_read(addrs[i], data, err);
            check_word($sformatf("prdata at 0x%0h", addrs[i]), data, value);
        end
        apb_read(8'h1C, data, err);
        check_bool("pslverr on read of 0x1c", err, 1'b1);
        apb_write(8'h1C, 32'h5, err);
        check_bool("pslverr on write of 0x1c", err, 1'b1);
        apb_write(ADDR_STATUS, 32'h3, err);
        check_bool("pslverr on write of STATUS", err, 1'b1);
        apb_read(ADDR_STATUS, data, err);
        check_word("prdata at STATUS", data, 32'h0);
    endtask

    task automatic test_sps();
        logic [31:0] data;
        logic err;
        write_params(MODE_SPS, 200, 80, 40, 0);
        send_cmd(3'b100);
        wait_command_done();
        send_cmd(3'b001);
        wait_command_done();
        check_pwm(expected_edges(MODE_SPS, 200, 80, 40, 0), 200);
        apb_read(ADDR_STATUS, data, err);
        check_status("status", dab_status_t'(data[1:0]), '{running: 1'b1, busy: 1'b0});
    endtask

    task automatic test_dps();
        write_params(MODE_DPS, 200, 80, 40, 20);
        update_running(200);
        check_pwm(expected_edges(MODE_DPS, 200, 80, 40, 20), 200);
    endtask

    task automatic test_duty_update();
        logic err;
        apb_write(ADDR_DUTY, 32'd100, err);
        check_bool("pslverr", err, 1'b0);
        update_running(200);
        check_status("status", status, '{running: 1'b1, busy: 1'b0});
        check_pwm(expected_edges(MODE_DPS, 200, 100, 40, 20), 200);
    endtask

    task automatic test_stop_start();
        logic [31:0] data;
        logic err;
        send_cmd(3'b010);
        wait_command_done();
        repeat (2) next_cycle();
        repeat (200) begin
            @(negedge clock);
            check_word("pwm_out", 32'(pwm_out), 32'h0);
        end
        next_cycle();
        apb_read(ADDR_STATUS, data, err);
        check_status("status", dab_status_t'(data[1:0]), '0);
        send_cmd(3'b001);
        wait_command_done();
        check_pwm(expected_edges(MODE_DPS, 200, 100, 40, 20), 200);
    endtask

    // The second update lands while busy is high and must be ignored
    task automatic test_update_while_busy();
        send_cmd(3'b100);
        send_cmd(3'b100);
        wait_command_done();
        repeat (12) begin
            @(negedge clock);
            check_status("status", status, '{running: 1'b1, busy: 1'b0});
        end
        next_cycle();
    endtask

    initial begin
        seed = 41;
        reset = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        repeat (4) @(posedge clock);
        #1;
        reset = 1'b1;
        test_registers();
        test_sps();
        test_dps();
        test_duty_update();
        test_stop_start();
        test_update_while_busy();
        if (assertion_failures() == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            fail_run("A bound assertion in dab_props failed");
        end
    end

endmodule

`default_nettype wire

//--- dv/dab_props.sv
// Assertions for the controller and PWM core; each bound copy ties off the ports of the other block
`timescale 1ns/1ps
`default_nettype none

module dab_props (
    input wire logic clock,
    input wire logic reset,
    input wire dab_pkg::ctrl_state_e state,
    input wire logic wr_valid,
    input wire logic busy,
    input wire logic enable,
    input wire logic [dab_pkg::N_CH-1:0] pwm_out
);
    import dab_pkg::*;

    int fail_count = 0;

    // pwm_out is cleared on the same edge that drops enable
    assert property (@(posedge clock) disable iff (!reset) !enable |-> pwm_out == '0)
        else begin
            fail_count++;
            $error("pwm_out is active while the generator is disabled");
        end

    // An update holds busy for eleven cycles, start and stop for fewer
    assert property (@(posedge clock) disable iff (!reset) $rose(busy) |-> ##[1:11] !busy)
        else begin
            fail_count++;
            $error("busy stayed high longer than 11 cycles");
        end

    // The write register lags the FSM state by one cycle
    assert property (@(posedge clock) disable iff (!reset)
        wr_valid |-> $past(state) inside {ST_WRITE, ST_ENABLE, ST_DISABLE})
        else begin
            fail_count++;
            $error("PWM write issued outside a write, enable or disable state");
        end

endmodule

bind dab_modulator_ctrl dab_props ctrl_props (
    .clock(clock), .reset(reset), .state(state), .wr_valid(pwm_wr.valid),
    .busy(status.busy), .enable(1'b0), .pwm_out('0)
);

bind dab_pwm_core dab_props pwm_props (
    .clock(clock), .reset(reset), .state(dab_pkg::ST_WRITE), .wr_valid(1'b0),
    .busy(1'b0), .enable(enable), .pwm_out(pwm_out)
);

`default_nettype wire

//--- rtl/dab_top.sv
// DAB pre-modulation top; APB3 slave with no wait states driving four PWM outputs
`timescale 1ns/1ps
`default_nettype none

module dab_top (
    input wire logic clock,
    input wire logic reset,
    input wire logic psel,
    input wire logic penable,
    input wire logic pwrite,
    input wire logic [dab_pkg::APB_AW-1:0] paddr,
    input wire logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic pready,
    output logic pslverr,
    output logic [dab_pkg::N_CH-1:0] pwm_out,
    output dab_pkg::dab_status_t status
);
    import dab_pkg::*;

    dab_params_t params;
    dab_cmd_t cmd;
    edge_set_t edges;
    pwm_write_t pwm_wr;
    logic calc_start;
    logic calc_done;

    dab_apb_regs regs (
        .clock(clock), .reset(reset), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .status(status), .params(params), .cmd(cmd)
    );

    dab_compare_calc calc (
        .clock(clock), .reset(reset), .calc_start(calc_start), .params(params),
        .edges(edges), .calc_done(calc_done)
    );

    dab_modulator_ctrl ctrl (
        .clock(clock), .reset(reset), .params(params), .cmd(cmd), .calc_start(calc_start),
        .edges(edges), .calc_done(calc_done), .pwm_wr(pwm_wr), .status(status)
    );

    dab_pwm_core pwm (
        .clock(clock), .reset(reset), .pwm_wr(pwm_wr), .pwm_out(pwm_out)
    );

endmodule

`default_nettype wire

//--- rtl/dab_pwm_core.sv
// Four-channel PWM; no dead time, edges must satisfy 0 <= rise < fall <= period
`timescale 1ns/1ps
`default_nettype none

module dab_pwm_core (
    input wire logic clock,
    input wire logic reset,
    input wire dab_pkg::pwm_write_t pwm_wr,
    output logic [dab_pkg::N_CH-1:0] pwm_out
);
    import dab_pkg::*;

    logic [DATA_W-1:0] shadow_period;
    logic [DATA_W-1:0] active_period;
    edge_set_t shadow_edges;
    edge_set_t active_edges;
    logic [DATA_W-1:0] count;
    logic enable;
    logic enable_wr;
    logic wrap;
    logic load;
    logic [CH_W-1:0] wr_ch;

    assign enable_wr = pwm_wr.valid && pwm_wr.target == REG_ENABLE;
    assign wrap = enable && count == active_period - DATA_W'(1);
    // The active set also loads when the generator is switched on
    assign load = wrap || (enable_wr && pwm_wr.data[0] && !enable);
    assign wr_ch = CH_W'(pwm_wr.target - REG_RISE0);

    always_ff @(posedge clock) begin
        if (pwm_wr.valid) begin
            case (pwm_wr.target)
                REG_PERIOD: shadow_period <= pwm_wr.data;
                REG_RISE0, REG_RISE1, REG_RISE2, REG_RISE3:
                    shadow_edges.rise[wr_ch] <= pwm_wr.data;
                REG_FALL0, REG_FALL1, REG_FALL2, REG_FALL3:
                    shadow_edges.fall[wr_ch] <= pwm_wr.data;
                default: ;
            endcase
        end
        if (load) begin
            active_period <= shadow_period;
            active_edges <= shadow_edges;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            enable <= 1'b0;
            count <= '0;
            pwm_out <= '0;
        end else begin
            if (enable_wr) begin
                enable <= pwm_wr.data[0];
            end
            if (!enable || (enable_wr && !pwm_wr.data[0])) begin
                count <= '0;
                pwm_out <= '0;
            end else begin
                count <= wrap ? '0 : count + DATA_W'(1);
                for (int k = 0; k < N_CH; k++) begin
                    pwm_out[k] <= count >= active_edges.rise[k] && count < active_edges.fall[k];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/dab_modulator_ctrl.sv
// Sequencer for calc and PWM writes; commands seen while busy are dropped and stop beats start
`timescale 1ns/1ps
`default_nettype none

module dab_modulator_ctrl (
    input wire logic clock,
    input wire logic reset,
    input wire dab_pkg::dab_params_t params,
    input wire dab_pkg::dab_cmd_t cmd,
    output logic calc_start,
    input wire dab_pkg::edge_set_t edges,
    input wire logic calc_done,
    output dab_pkg::pwm_write_t pwm_wr,
    output dab_pkg::dab_status_t status
);
    import dab_pkg::*;

    ctrl_state_e state;
    ctrl_state_e state_next;
    pwm_reg_e wr_reg;
    logic [CH_W-1:0] wr_ch;
    logic [DATA_W-1:0] wr_data;
    logic accept;

    assign accept = (state == ST_IDLE) && !status.busy;

    // Parameters are sampled in the same cycle the update pulse is taken
    assign calc_start = accept && cmd.update && !cmd.start && !cmd.stop;

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (accept) begin
                    if (cmd.stop) begin
                        state_next = ST_DISABLE;
                    end else if (cmd.start) begin
                        state_next = ST_ENABLE;
                    end else if (cmd.update) begin
                        state_next = ST_CALC;
                    end
                end
            end
            ST_CALC: begin
                if (calc_done) begin
                    state_next = ST_WRITE;
                end
            end
            ST_WRITE: begin
                if (wr_reg == REG_FALL3) begin
                    state_next = ST_IDLE;
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

    // Rise k and fall k sit at opcodes k+1 and k+5, so the low bits of index-1 give the channel
    assign wr_ch = CH_W'(wr_reg - REG_RISE0);

    always_comb begin
        if (wr_reg == REG_PERIOD) begin
            wr_data = params.period;
        end else if (wr_reg <= REG_RISE3) begin
            wr_data = edges.rise[wr_ch];
        end else begin
            wr_data = edges.fall[wr_ch];
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= ST_IDLE;
            wr_reg <= REG_PERIOD;
            pwm_wr <= '0;
            status <= '0;
        end else begin
            state <= state_next;
            // Covers the cycle after the last write leaves the FSM
            status.busy <= (state_next != ST_IDLE) || (state != ST_IDLE);
            pwm_wr.valid <= 1'b0;
            case (state)
                ST_CALC: wr_reg <= REG_PERIOD;
                ST_WRITE: begin
                    pwm_wr <= '{valid: 1'b1, target: wr_reg, data: wr_data};
                    wr_reg <= pwm_reg_e'(wr_reg + 1);
                end
                ST_ENABLE: begin
                    pwm_wr <= '{valid: 1'b1, target: REG_ENABLE, data: DATA_W'(1)};
                    status.running <= 1'b1;
                end
                ST_DISABLE: begin
                    pwm_wr <= '{valid: 1'b1, target: REG_ENABLE, data: '0};
                    status.running <= 1'b0;
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/dab_compare_calc.sv
// SPS/DPS edge calculation in one cycle; results that fall outside 0..period are not clamped
`timescale 1ns/1ps
`default_nettype none

module dab_compare_calc (
    input wire logic clock,
    input wire logic reset,
    input wire logic calc_start,
    input wire dab_pkg::dab_params_t params,
    output dab_pkg::edge_set_t edges,
    output logic calc_done
);
    import dab_pkg::*;

    // Two extra bits keep the signed sums from overflowing before truncation
    logic signed [DATA_W+1:0] half_period;
    logic signed [DATA_W+1:0] half_duty;
    logic signed [DATA_W+1:0] p1;
    logic signed [DATA_W+1:0] p2;
    logic signed [DATA_W+1:0] shift [N_CH];
    logic signed [DATA_W+1:0] rise_sum [N_CH];
    logic signed [DATA_W+1:0] fall_sum [N_CH];

    assign half_period = $signed({2'b00, params.period}) / 2;
    assign half_duty = $signed({2'b00, params.duty}) / 2;
    assign p1 = params.phase_1 / 2;
    assign p2 = params.phase_2 / 2;

    always_comb begin
        shift[0] = '0;
        if (params.mode == MODE_SPS) begin
            shift[1] = '0;
            shift[2] = p1;
            shift[3] = p1;
        end else begin
            shift[1] = p2;
            shift[2] = p1;
            shift[3] = p1 + p2;
        end
        for (int k = 0; k < N_CH; k++) begin
            rise_sum[k] = half_period - half_duty + shift[k];
            fall_sum[k] = half_period + half_duty + shift[k];
        end
    end

    always_ff @(posedge clock) begin
        if (calc_start) begin
            for (int k = 0; k < N_CH; k++) begin
                edges.rise[k] <= rise_sum[k][DATA_W-1:0];
                edges.fall[k] <= fall_sum[k][DATA_W-1:0];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            calc_done <= 1'b0;
        end else begin
            calc_done <= calc_start;
        end
    end

endmodule

`default_nettype wire

//--- rtl/dab_apb_regs.sv
// APB3 register block without wait states; CTRL is write-only and reads as zero, STATUS is read-only
`timescale 1ns/1ps
`default_nettype none

module dab_apb_regs (
    input wire logic clock,
    input wire logic reset,
    input wire logic psel,
    input wire logic penable,
    input wire logic pwrite,
    input wire logic [dab_pkg::APB_AW-1:0] paddr,
    input wire logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic pready,
    output logic pslverr,
    input wire dab_pkg::dab_status_t status,
    output dab_pkg::dab_params_t params,
    output dab_pkg::dab_cmd_t cmd
);
    import dab_pkg::*;

    logic access;
    logic addr_ok;

    assign access = psel && penable;
    assign pready = access;

    always_comb begin
        case (paddr)
            ADDR_CTRL, ADDR_MODE, ADDR_PERIOD, ADDR_DUTY,
            ADDR_PHASE1, ADDR_PHASE2, ADDR_STATUS: addr_ok = 1'b1;
            default: addr_ok = 1'b0;
        endcase
    end

    assign pslverr = access && (!addr_ok || (pwrite && paddr == ADDR_STATUS));

    // Command bits only live for the cycle after the write
    always_ff @(posedge clock) begin
        if (!reset) begin
            params <= '0;
            cmd <= '0;
        end else begin
            cmd <= '0;
            if (access && pwrite) begin
                case (paddr)
                    ADDR_CTRL: cmd <= '{start: pwdata[0], stop: pwdata[1], update: pwdata[2]};
                    ADDR_MODE: params.mode <= mod_mode_e'(pwdata[0]);
                    ADDR_PERIOD: params.period <= pwdata[DATA_W-1:0];
                    ADDR_DUTY: params.duty <= pwdata[DATA_W-1:0];
                    ADDR_PHASE1: params.phase_1 <= pwdata[DATA_W-1:0];
                    ADDR_PHASE2: params.phase_2 <= pwdata[DATA_W-1:0];
                    default: ;
                endcase
            end
        end
    end

    // Phases come back as raw bits, zero-extended
    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            case (paddr)
                ADDR_MODE: prdata = {31'b0, params.mode};
                ADDR_PERIOD: prdata = {{(32-DATA_W){1'b0}}, params.period};
                ADDR_DUTY: prdata = {{(32-DATA_W){1'b0}}, params.duty};
                ADDR_PHASE1: prdata = {{(32-DATA_W){1'b0}}, params.phase_1};
                ADDR_PHASE2: prdata = {{(32-DATA_W){1'b0}}, params.phase_2};
                ADDR_STATUS: prdata = {{(32-$bits(dab_status_t)){1'b0}}, status};
                default: prdata = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/dab_pkg.sv
// Shared types for the DAB modulator; four channels and 16-bit compare values are fixed
`default_nettype none

package dab_pkg;

    localparam int DATA_W = 16;
    localparam int N_CH = 4;
    localparam int CH_W = $clog2(N_CH);
    localparam int APB_AW = 8;

    // Register map, byte offsets
    localparam logic [APB_AW-1:0] ADDR_CTRL = 8'h00;
    localparam logic [APB_AW-1:0] ADDR_MODE = 8'h04;
    localparam logic [APB_AW-1:0] ADDR_PERIOD = 8'h08;
    localparam logic [APB_AW-1:0] ADDR_DUTY = 8'h0C;
    localparam logic [APB_AW-1:0] ADDR_PHASE1 = 8'h10;
    localparam logic [APB_AW-1:0] ADDR_PHASE2 = 8'h14;
    localparam logic [APB_AW-1:0] ADDR_STATUS = 8'h18;

    typedef enum logic {
        MODE_SPS = 1'b0,
        MODE_DPS = 1'b1
    } mod_mode_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CALC,
        ST_WRITE,
        ST_ENABLE,
        ST_DISABLE
    } ctrl_state_e;

    // The controller walks these in order, so the rise and fall blocks must stay contiguous
    typedef enum logic [3:0] {
        REG_PERIOD = 4'd0,
        REG_RISE0 = 4'd1,
        REG_RISE1 = 4'd2,
        REG_RISE2 = 4'd3,
        REG_RISE3 = 4'd4,
        REG_FALL0 = 4'd5,
        REG_FALL1 = 4'd6,
        REG_FALL2 = 4'd7,
        REG_FALL3 = 4'd8,
        REG_ENABLE = 4'd9
    } pwm_reg_e;

    typedef struct packed {
        logic valid;
        pwm_reg_e target;
        logic [DATA_W-1:0] data;
    } pwm_write_t;

    typedef struct packed {
        mod_mode_e mode;
        logic [DATA_W-1:0] period;
        logic [DATA_W-1:0] duty;
        logic signed [DATA_W-1:0] phase_1;
        logic signed [DATA_W-1:0] phase_2;
    } dab_params_t;

    typedef struct packed {
        logic start;
        logic stop;
        logic update;
    } dab_cmd_t;

    typedef struct packed {
        logic [N_CH-1:0][DATA_W-1:0] rise;
        logic [N_CH-1:0][DATA_W-1:0] fall;
    } edge_set_t;

    typedef struct packed {
        logic running;
        logic busy;
    } dab_status_t;

endpackage

`default_nettype wire
